// ==== list.f ====
+incdir+rtl
rtl/cpu16_pkg.sv
rtl/boot_loader.sv
rtl/inst_ram.sv
rtl/reg_file.sv
rtl/alu.sv
rtl/cpu16_core.sv
rtl/seg_display.sv
rtl/cpu16_top.sv
testbench/cpu16_tb.sv

// ==== rtl/alu.sv ====
`default_nettype none
`timescale 1ns/1ps

module alu (
	input  cpu16_pkg::alu_op_e op,
	input  wire [15:0]         a,
	input  wire [15:0]         b,
	output logic [15:0]        y,
	output logic               zero
);

	always_comb begin
		case (op)
			cpu16_pkg::ALU_ADD: begin
				y = a + b;
			end
			cpu16_pkg::ALU_SUB: begin
				y = a - b;
			end
			cpu16_pkg::ALU_AND: begin
				y = a & b;
			end
			cpu16_pkg::ALU_OR: begin
				y = a | b;
			end
			cpu16_pkg::ALU_PASS_B: begin
				y = b;
			end
			default: begin
				y = '0;
			end
		endcase
	end

	assign zero = (y == 16'd0);

endmodule

`default_nettype wire

// ==== rtl/boot_loader.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "cpu16_defines.svh"

module boot_loader (
	input  wire                         clk,
	input  wire                         arst_n,
	input  wire                         flash_valid,
	input  wire [15:0]                  flash_data,
	output logic                        flash_rd,
	output logic [`CPU16_FLASH_AW-1:0]  flash_addr,
	output cpu16_pkg::iram_wr_t         iram_wr,
	output logic                        boot_done,
	output logic [`CPU16_IRAM_AW-1:0]   boot_addr
);

	cpu16_pkg::boot_state_e state;
	logic [15:0] remaining;
	logic        wr_en;
	logic [15:0] wr_data;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state      <= cpu16_pkg::BOOT_IDLE;
			flash_rd   <= 1'b0;
			flash_addr <= '0;
			remaining  <= '0;
			wr_en      <= 1'b0;
			boot_addr  <= '0;
		end else begin
			flash_rd <= 1'b0;
			wr_en    <= 1'b0;
			case (state)
				cpu16_pkg::BOOT_IDLE: begin
					// Length word lives at flash address 0
					flash_rd   <= 1'b1;
					flash_addr <= '0;
					state      <= cpu16_pkg::BOOT_READ_LEN;
				end
				cpu16_pkg::BOOT_READ_LEN: begin
					if (flash_valid) begin
						remaining <= flash_data;
						if (flash_data == 16'd0) begin
							state <= cpu16_pkg::BOOT_DONE;
						end else begin
							flash_rd   <= 1'b1;
							flash_addr <= flash_addr + 1'b1;
							state      <= cpu16_pkg::BOOT_READ_WORD;
						end
					end
				end
				cpu16_pkg::BOOT_READ_WORD: begin
					if (flash_valid) begin
						wr_en <= 1'b1;
						state <= cpu16_pkg::BOOT_WRITE;
					end
				end
				cpu16_pkg::BOOT_WRITE: begin
					boot_addr <= boot_addr + 1'b1;
					remaining <= remaining - 1'b1;
					if (remaining == 16'd1) begin
						state <= cpu16_pkg::BOOT_DONE;
					end else begin
						flash_rd   <= 1'b1;
						flash_addr <= flash_addr + 1'b1;
						state      <= cpu16_pkg::BOOT_READ_WORD;
					end
				end
				default: state <= cpu16_pkg::BOOT_DONE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (flash_valid) begin
			wr_data <= flash_data;
		end
	end

	assign iram_wr   = '{en: wr_en, addr: boot_addr, data: wr_data};
	assign boot_done = (state == cpu16_pkg::BOOT_DONE);

endmodule

`default_nettype wire

// ==== rtl/cpu16_core.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "cpu16_defines.svh"

module cpu16_core (
	input  wire                         clk,
	input  wire                         arst_n,
	input  wire                         boot_done,
	input  wire [15:0]                  iram_rdata,
	output logic [`CPU16_IRAM_AW-1:0]   iram_raddr,
	output cpu16_pkg::out_port_t        result,
	output logic                        halted,
	output logic [`CPU16_IRAM_AW-1:0]   pc
);

	cpu16_pkg::core_state_e state;
	cpu16_pkg::instr_t      instr;
	cpu16_pkg::alu_op_e     alu_op;
	cpu16_pkg::rf_wr_t      rf_wr;

	logic [7:0]  imm8;
	logic [15:0] imm_zext;
	logic [15:0] imm_sext;
	logic [15:0] ra_data;
	logic [15:0] rb_data;
	logic [15:0] rc_data;
	logic [15:0] alu_a;
	logic [15:0] alu_b;
	logic [15:0] alu_y;
	logic        alu_zero;
	logic        wb_en;
	logic        is_branch;
	logic        is_out;
	logic        is_halt;
	logic        executing;
	logic [`CPU16_IRAM_AW-1:0] pc_inc;
	logic [`CPU16_IRAM_AW-1:0] pc_next;

	assign instr    = cpu16_pkg::instr_t'(iram_rdata);
	assign imm8     = iram_rdata[7:0];
	assign imm_zext = {8'h00, imm8};
	assign imm_sext = {{8{imm8[7]}}, imm8};

	reg_file u_reg_file (
		.clk     (clk),
		.arst_n  (arst_n),
		.ra_addr (instr.ra),
		.rb_addr (instr.rb),
		.rc_addr (instr.rc),
		.wr      (rf_wr),
		.ra_data (ra_data),
		.rb_data (rb_data),
		.rc_data (rc_data)
	);

	// Decode
	always_comb begin
		alu_op    = cpu16_pkg::ALU_ADD;
		alu_a     = rb_data;
		alu_b     = rc_data;
		wb_en     = 1'b0;
		is_branch = 1'b0;
		is_out    = 1'b0;
		is_halt   = 1'b0;
		case (instr.op)
			cpu16_pkg::OP_LI: begin
				alu_op = cpu16_pkg::ALU_PASS_B;
				alu_b  = imm_zext;
				wb_en  = 1'b1;
			end
			cpu16_pkg::OP_ADDIU: begin
				alu_a = ra_data;
				alu_b = imm_sext;
				wb_en = 1'b1;
			end
			cpu16_pkg::OP_ADDU: begin
				wb_en = 1'b1;
			end
			cpu16_pkg::OP_SUBU: begin
				alu_op = cpu16_pkg::ALU_SUB;
				wb_en  = 1'b1;
			end
			cpu16_pkg::OP_AND: begin
				alu_op = cpu16_pkg::ALU_AND;
				wb_en  = 1'b1;
			end
			cpu16_pkg::OP_OR: begin
				alu_op = cpu16_pkg::ALU_OR;
				wb_en  = 1'b1;
			end
			cpu16_pkg::OP_BEQZ: begin
				// Zero test of ra through the ALU
				alu_op    = cpu16_pkg::ALU_PASS_B;
				alu_b     = ra_data;
				is_branch = 1'b1;
			end
			cpu16_pkg::OP_OUT: begin
				is_out = 1'b1;
			end
			cpu16_pkg::OP_HALT: begin
				is_halt = 1'b1;
			end
			default: begin
			end
		endcase
	end

	alu u_alu (
		.op   (alu_op),
		.a    (alu_a),
		.b    (alu_b),
		.y    (alu_y),
		.zero (alu_zero)
	);

	assign executing = (state == cpu16_pkg::CORE_EXECUTE);

	// Offset truncates to PC width, wraps with the PC
	assign pc_inc  = pc + 1'b1;
	assign pc_next = (is_branch && alu_zero) ? pc_inc + imm_sext[`CPU16_IRAM_AW-1:0] : pc_inc;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= cpu16_pkg::CORE_WAIT_BOOT;
			pc    <= '0;
		end else begin
			case (state)
				cpu16_pkg::CORE_WAIT_BOOT: begin
					pc <= '0;
					if (boot_done) begin
						state <= cpu16_pkg::CORE_FETCH;
					end
				end
				cpu16_pkg::CORE_FETCH: begin
					state <= cpu16_pkg::CORE_EXECUTE;
				end
				cpu16_pkg::CORE_EXECUTE: begin
					if (is_halt) begin
						state <= cpu16_pkg::CORE_HALTED;
					end else begin
						pc    <= pc_next;
						state <= cpu16_pkg::CORE_FETCH;
					end
				end
				default: state <= cpu16_pkg::CORE_HALTED;
			endcase
		end
	end

	assign rf_wr      = '{en: executing && wb_en, addr: instr.ra, data: alu_y};
	assign result     = '{valid: executing && is_out, value: ra_data};
	assign halted     = (state == cpu16_pkg::CORE_HALTED);
	assign iram_raddr = pc;

endmodule

`default_nettype wire

// ==== rtl/cpu16_defines.svh ====
`ifndef CPU16_DEFINES_SVH
`define CPU16_DEFINES_SVH

// Instruction memory geometry
`define CPU16_IRAM_AW    6
`define CPU16_IRAM_DEPTH 64

// Register file
`define CPU16_NUM_REGS   8
`define CPU16_REG_AW     3

// Flash word address
`define CPU16_FLASH_AW   8

`endif

// ==== rtl/cpu16_pkg.sv ====
`default_nettype none
`include "cpu16_defines.svh"

package cpu16_pkg;

	typedef enum logic [3:0] {
		OP_LI    = 4'd1,
		OP_ADDIU = 4'd2,
		OP_ADDU  = 4'd3,
		OP_SUBU  = 4'd4,
		OP_AND   = 4'd5,
		OP_OR    = 4'd6,
		OP_BEQZ  = 4'd7,
		OP_OUT   = 4'd8,
		OP_HALT  = 4'd15
	} opcode_e;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_PASS_B
	} alu_op_e;

	typedef enum logic [2:0] {
		BOOT_IDLE,
		BOOT_READ_LEN,
		BOOT_READ_WORD,
		BOOT_WRITE,
		BOOT_DONE
	} boot_state_e;

	typedef enum logic [1:0] {
		CORE_WAIT_BOOT,
		CORE_FETCH,
		CORE_EXECUTE,
		CORE_HALTED
	} core_state_e;

	// imm8 overlays the low byte for immediate forms
	typedef struct packed {
		opcode_e    op;
		logic [2:0] ra;
		logic [2:0] rb;
		logic [2:0] rc;
		logic [2:0] unused;
	} instr_t;

	typedef struct packed {
		logic                      en;
		logic [`CPU16_IRAM_AW-1:0] addr;
		logic [15:0]               data;
	} iram_wr_t;

	typedef struct packed {
		logic                     en;
		logic [`CPU16_REG_AW-1:0] addr;
		logic [15:0]              data;
	} rf_wr_t;

	typedef struct packed {
		logic        valid;
		logic [15:0] value;
	} out_port_t;

endpackage

`default_nettype wire

// ==== rtl/cpu16_top.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "cpu16_defines.svh"

module cpu16_top (
	input  wire                         clk,
	input  wire                         arst_n,
	input  wire                         flash_valid,
	input  wire [15:0]                  flash_data,
	output logic                        flash_rd,
	output logic [`CPU16_FLASH_AW-1:0]  flash_addr,
	output logic [6:0]                  seg_hi,
	output logic [6:0]                  seg_lo,
	output logic [15:0]                 led,
	output cpu16_pkg::out_port_t        result,
	output logic                        halted,
	output logic                        boot_done
);

	cpu16_pkg::iram_wr_t        iram_wr;
	logic [`CPU16_IRAM_AW-1:0]  iram_raddr;
	logic [15:0]                iram_rdata;
	logic [`CPU16_IRAM_AW-1:0]  boot_addr;
	logic [`CPU16_IRAM_AW-1:0]  pc;

	boot_loader u_boot_loader (
		.clk         (clk),
		.arst_n      (arst_n),
		.flash_valid (flash_valid),
		.flash_data  (flash_data),
		.flash_rd    (flash_rd),
		.flash_addr  (flash_addr),
		.iram_wr     (iram_wr),
		.boot_done   (boot_done),
		.boot_addr   (boot_addr)
	);

	inst_ram u_inst_ram (
		.clk   (clk),
		.wr    (iram_wr),
		.raddr (iram_raddr),
		.rdata (iram_rdata)
	);

	cpu16_core u_core (
		.clk        (clk),
		.arst_n     (arst_n),
		.boot_done  (boot_done),
		.iram_rdata (iram_rdata),
		.iram_raddr (iram_raddr),
		.result     (result),
		.halted     (halted),
		.pc         (pc)
	);

	seg_display u_seg_display (
		.clk       (clk),
		.arst_n    (arst_n),
		.boot_done (boot_done),
		.boot_addr (boot_addr),
		.pc        (pc),
		.result    (result),
		.seg_hi    (seg_hi),
		.seg_lo    (seg_lo),
		.led       (led)
	);

endmodule

`default_nettype wire

// ==== rtl/inst_ram.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "cpu16_defines.svh"

module inst_ram (
	input  wire                       clk,
	input  cpu16_pkg::iram_wr_t       wr,
	input  wire [`CPU16_IRAM_AW-1:0]  raddr,
	output logic [15:0]               rdata
);

	logic [15:0] mem [`CPU16_IRAM_DEPTH];

	always_ff @(posedge clk) begin
		if (wr.en) begin
			mem[wr.addr] <= wr.data;
		end
	end

	// Registered read, data follows the address by one cycle
	always_ff @(posedge clk) begin
		rdata <= mem[raddr];
	end

endmodule

`default_nettype wire

// ==== rtl/reg_file.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "cpu16_defines.svh"

module reg_file (
	input  wire                      clk,
	input  wire                      arst_n,
	input  wire [`CPU16_REG_AW-1:0]  ra_addr,
	input  wire [`CPU16_REG_AW-1:0]  rb_addr,
	input  wire [`CPU16_REG_AW-1:0]  rc_addr,
	input  cpu16_pkg::rf_wr_t        wr,
	output logic [15:0]              ra_data,
	output logic [15:0]              rb_data,
	output logic [15:0]              rc_data
);

	logic [15:0] regs [`CPU16_NUM_REGS];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `CPU16_NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr.en) begin
			regs[wr.addr] <= wr.data;
		end
	end

	// No bypass, a write shows up on the next read
	assign ra_data = regs[ra_addr];
	assign rb_data = regs[rb_addr];
	assign rc_data = regs[rc_addr];

endmodule

`default_nettype wire

// ==== rtl/seg_display.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "cpu16_defines.svh"

module seg_display (
	input  wire                        clk,
	input  wire                        arst_n,
	input  wire                        boot_done,
	input  wire [`CPU16_IRAM_AW-1:0]   boot_addr,
	input  wire [`CPU16_IRAM_AW-1:0]   pc,
	input  cpu16_pkg::out_port_t       result,
	output logic [6:0]                 seg_hi,
	output logic [6:0]                 seg_lo,
	output logic [15:0]                led
);

	logic [7:0] shown;

	// Segment bits are g down to a
	function automatic logic [6:0] hex_to_seg(input logic [3:0] nib);
		logic [6:0] seg;
		case (nib)
			4'h0: seg = 7'h3F;
			4'h1: seg = 7'h06;
			4'h2: seg = 7'h5B;
			4'h3: seg = 7'h4F;
			4'h4: seg = 7'h66;
			4'h5: seg = 7'h6D;
			4'h6: seg = 7'h7D;
			4'h7: seg = 7'h07;
			4'h8: seg = 7'h7F;
			4'h9: seg = 7'h6F;
			4'hA: seg = 7'h77;
			4'hB: seg = 7'h7C;
			4'hC: seg = 7'h39;
			4'hD: seg = 7'h5E;
			4'hE: seg = 7'h79;
			default: seg = 7'h71;
		endcase
		return seg;
	endfunction

	assign shown = boot_done ? 8'(pc) : 8'(boot_addr);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			seg_hi <= '0;
			seg_lo <= '0;
			led    <= '0;
		end else begin
			seg_hi <= hex_to_seg(shown[7:4]);
			seg_lo <= hex_to_seg(shown[3:0]);
			if (result.valid) begin
				led <= result.value;
			end
		end
	end

endmodule

`default_nettype wire

// ==== testbench/cpu16_tb.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "cpu16_defines.svh"

module cpu16_tb;

	localparam int FLASH_WORDS = 1 << `CPU16_FLASH_AW;
	localparam int EXP_BASE    = 'h80;
	localparam int MAX_STEPS   = 200;

	// Digit glyphs, bits g down to a
	localparam logic [6:0] GLYPHS [16] = '{
		7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
		7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71
	};

	logic                       clk = 1'b0;
	logic                       arst_n;
	logic                       flash_valid;
	logic [15:0]                flash_data;
	logic                       flash_rd;
	logic [`CPU16_FLASH_AW-1:0] flash_addr;
	logic [6:0]                 seg_hi;
	logic [6:0]                 seg_lo;
	logic [15:0]                led;
	cpu16_pkg::out_port_t       result;
	logic                       halted;
	logic                       boot_done;

	logic [15:0] image [FLASH_WORDS];
	int          n_words;
	int          n_out;
	logic [7:0]  halt_pc;
	int          errors = 0;
	int          cycles = 0;
	int          cycle_limit = 1000;
	int          seed_ret;
	int          out_idx = 0;
	int          outs_total = 0;
	bit          timed_out = 1'b0;
	bit          boot_seen = 1'b0;
	bit          halted_seen = 1'b0;

	// Flash model and boot address tracking
	bit          pending = 1'b0;
	int          wait_left = 0;
	logic [7:0]  rd_addr = '0;
	int          exp_rd_addr = 0;
	int          bump_in = 0;
	int          since_valid = 0;
	logic [7:0]  model_addr = '0;
	bit          prev_live = 1'b0;
	bit          prev_boot_done = 1'b0;
	logic [7:0]  prev_addr = '0;

	cpu16_top DUT (
		.clk         (clk),
		.arst_n      (arst_n),
		.flash_valid (flash_valid),
		.flash_data  (flash_data),
		.flash_rd    (flash_rd),
		.flash_addr  (flash_addr),
		.seg_hi      (seg_hi),
		.seg_lo      (seg_lo),
		.led         (led),
		.result      (result),
		.halted      (halted),
		.boot_done   (boot_done)
	);

	always #4 clk = ~clk;

	task automatic check_word(input string name, input logic [15:0] act, input logic [15:0] exp);
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %s: got %h, expected %h", name, act, exp);
		end
	endtask

	task automatic check_seg(input string name, input logic [6:0] act, input logic [3:0] nib);
		if (act !== GLYPHS[nib]) begin
			errors++;
			$display("[ERROR] %s: got %h, expected %h for digit %h", name, act, GLYPHS[nib], nib);
		end
	endtask

	task automatic check_result(input cpu16_pkg::out_port_t act, input cpu16_pkg::out_port_t exp);
		if (act !== exp) begin
			errors++;
			$display("[ERROR] result: got valid=%h value=%h, expected valid=%h value=%h",
				act.valid, act.value, exp.valid, exp.value);
		end
	endtask

	task automatic report_and_finish();
		$display("Errors: %0d, OUT values checked: %0d, cycles: %0d", errors, outs_total, cycles);
		if (errors == 0 && !timed_out) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	endtask

	// Answers each read after 1 to 6 cycles
	task automatic serve_flash();
		flash_valid = 1'b0;
		if (!arst_n) begin
			pending     = 1'b0;
			exp_rd_addr = 0;
			model_addr  = '0;
			bump_in     = 0;
			since_valid = 0;
		end else begin
			since_valid++;
			// Write lands one cycle after valid, address moves on at its end
			if (bump_in > 0) begin
				bump_in--;
				if (bump_in == 0) begin
					model_addr++;
				end
			end
			if (pending) begin
				if (wait_left == 0) begin
					flash_valid = 1'b1;
					flash_data  = image[rd_addr];
					pending     = 1'b0;
					since_valid = 0;
					if (rd_addr != 0) begin
						bump_in = 2;
					end
				end else begin
					wait_left--;
				end
			end
			if (flash_rd) begin
				if (pending) begin
					errors++;
					$display("A second flash read was issued while one was outstanding");
				end
				if (exp_rd_addr > n_words) begin
					errors++;
					$display("Flash read beyond the end of the program image");
				end
				check_word("flash_addr", 16'(flash_addr), 16'(exp_rd_addr));
				exp_rd_addr++;
				pending   = 1'b1;
				rd_addr   = flash_addr;
				wait_left = $urandom_range(5, 0);
			end
		end
	endtask

	task automatic watch_boot();
		if (!boot_done) begin
			check_word("halted", 16'(halted), 16'h0);
			check_word("result.valid", 16'(result.valid), 16'h0);
			if (boot_seen) begin
				errors++;
				$display("boot_done fell without a reset");
			end
		end else if (!boot_seen) begin
			boot_seen = 1'b1;
			if (pending || exp_rd_addr != n_words + 1) begin
				errors++;
				$display("boot_done rose before all %0d flash reads returned", n_words + 1);
			end else if (since_valid != 2) begin
				errors++;
				$display("boot_done rose %0d cycles after the last flash word, not 2", since_valid);
			end
		end
	endtask

	// One clock cycle, everything sampled at the falling edge
	task automatic step();
		cpu16_pkg::out_port_t exp_out;
		@(negedge clk);
		cycles++;
		if (cycles > cycle_limit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
			timed_out = 1'b1;
			report_and_finish();
		end else begin
			serve_flash();
			if (arst_n) begin
				watch_boot();
				if (prev_live && !prev_boot_done) begin
					check_seg("seg_hi", seg_hi, prev_addr[7:4]);
					check_seg("seg_lo", seg_lo, prev_addr[3:0]);
				end
				if (boot_done && result.valid) begin
					outs_total++;
					if (halted_seen) begin
						errors++;
						$display("Result strobe seen after HALT");
					end
					if (out_idx < n_out) begin
						exp_out.valid = 1'b1;
						exp_out.value = image[EXP_BASE + 1 + out_idx];
						check_result(result, exp_out);
					end else begin
						errors++;
						$display("Extra OUT value %h beyond the expected %0d", result.value, n_out);
					end
					out_idx++;
				end
				if (halted) begin
					halted_seen = 1'b1;
				end
			end
			prev_live      = arst_n;
			prev_boot_done = boot_done;
			prev_addr      = model_addr;
		end
	endtask

	task automatic apply_reset();
		arst_n      = 1'b0;
		out_idx     = 0;
		boot_seen   = 1'b0;
		halted_seen = 1'b0;
		step();
		check_word("led", led, 16'h0);
		check_word("halted", 16'(halted), 16'h0);
		check_word("boot_done", 16'(boot_done), 16'h0);
		step();
		arst_n = 1'b1;
	endtask

	task automatic run_to_halt();
		while (!halted) begin
			step();
		end
		// Idle a few cycles to catch late strobes and settle the digits
		repeat (4) begin
			step();
		end
		if (!boot_seen) begin
			errors++;
			$display("Core halted without boot_done having risen");
		end
		if (out_idx < n_out) begin
			errors++;
			$display("Missing OUT values: saw %0d of %0d", out_idx, n_out);
		end
		check_word("led", led, image[EXP_BASE + n_out]);
		check_word("halted", 16'(halted), 16'h1);
		check_seg("seg_hi", seg_hi, halt_pc[7:4]);
		check_seg("seg_lo", seg_lo, halt_pc[3:0]);
	endtask

	task automatic wait_for_outs(input int count);
		while (out_idx < count && !halted) begin
			step();
		end
	endtask

	initial begin
		arst_n      = 1'b0;
		flash_valid = 1'b0;
		flash_data  = 16'h0;
		seed_ret    = $urandom(32'h0435ca68);
		$readmemh("testbench/tb_input.mem", image);
		if ($isunknown(image[0]) || $isunknown(image[EXP_BASE])) begin
			errors++;
			$display("Stimulus file testbench/tb_input.mem could not be read");
			report_and_finish();
		end else begin
			n_words     = image[0];
			n_out       = image[EXP_BASE];
			halt_pc     = image[EXP_BASE + n_out + 1][7:0];
			cycle_limit = 3 * (8 * (n_words + 1) + 2 * MAX_STEPS) + 100;
			apply_reset();
			run_to_halt();
			// Reset in the middle of execution, then a full rerun
			apply_reset();
			wait_for_outs(3);
			apply_reset();
			run_to_halt();
			report_and_finish();
		end
	end

endmodule

`default_nettype wire

// ==== testbench/tb_input.mem ====
// Flash image: word 0 holds the program length N, words 1 to N the program
// At 80: count of expected OUT values, the values in order, then the halt PC
0017
1205 // LI r1, 0x05
8200 // OUT r1
22FD // ADDIU r1, -3
8200 // OUT r1
140A // LI r2, 0x0A
4650 // SUBU r3, r1, r2
8600 // OUT r3
38D0 // ADDU r4, r3, r2
8800 // OUT r4
1AF0 // LI r5, 0xF0
5D58 // AND r6, r5, r3
6F90 // OR r7, r6, r2
8E00 // OUT r7
1003 // LI r0, 3
1C00 // LI r6, 0
8000 // OUT r0, loop top
20FF // ADDIU r0, -1
7001 // BEQZ r0, +1
7CFC // BEQZ r6, -4
7E02 // BEQZ r7, +2, not taken
8400 // OUT r2
F000 // HALT
8200 // OUT r1, never reached
@80
0009
0005
0002
FFF8
0002
00FA
0003
0002
0001
000A
0015
